//--- design/saturn_ctrl_pkg.sv
package saturn_ctrl_pkg;

    // data widths
    typedef logic [3:0]  nibble_t;
    typedef logic [19:0] pc_t;
    typedef logic [15:0] instr_word_t;       // type | reg | ptr | imm
    typedef logic [3:0]  instr_type_t;
    typedef logic [3:0]  reg_sel_t;
    typedef logic [4:0]  bus_entry_t;        // bit 4 marks a command
    typedef logic [4:0]  prog_addr_t;
    typedef logic [1:0]  entry_src_t;

    localparam int C_NIBBLES    = 16;
    localparam int ADDR_NIBBLES = 5;

    // instruction types, as delivered by the decoder
    localparam instr_type_t INSTR_NOP       = 4'd0;
    localparam instr_type_t INSTR_P_EQ_N    = 4'd1;
    localparam instr_type_t INSTR_C_EQ_P    = 4'd2;
    localparam instr_type_t INSTR_CLRHST    = 4'd3;
    localparam instr_type_t INSTR_ST_EQ     = 4'd4;
    localparam instr_type_t INSTR_SET_MODE  = 4'd5;    // SETHEX / SETDEC
    localparam instr_type_t INSTR_SET_CARRY = 4'd6;    // carry on return
    localparam instr_type_t INSTR_LOAD      = 4'd7;
    localparam instr_type_t INSTR_CONFIG    = 4'd8;
    localparam instr_type_t INSTR_RESET     = 4'd9;    // highest supported code

    // register selects
    localparam reg_sel_t REG_C  = 4'd2;
    localparam reg_sel_t REG_D0 = 4'd4;

    // bus commands
    localparam nibble_t BUSCMD_PC_READ   = 4'd0;
    localparam nibble_t BUSCMD_LOAD_PC   = 4'd4;
    localparam nibble_t BUSCMD_CONFIGURE = 4'd5;
    localparam nibble_t BUSCMD_RESET     = 4'd6;

    // where a program entry comes from
    localparam entry_src_t SRC_CMD = 2'd0;
    localparam entry_src_t SRC_PC  = 2'd1;
    localparam entry_src_t SRC_C   = 2'd2;

    typedef enum logic [2:0] {
        ST_CLEAR,
        ST_LOAD_PC,
        ST_PC_NIBBLES,
        ST_IDLE,
        ST_ACK,
        ST_CFG_NIBBLES,
        ST_PC_READ
    } ctrl_state_t;

endpackage

//--- design/saturn_ctrl_fsm.sv
`timescale 1ns/1ns

module saturn_ctrl_fsm #(
    parameter int C_NIBBLES    = 16,
    parameter int ADDR_NIBBLES = 5
) (
    input  logic                          i_clk,
    input  logic                          i_reset,
    input  logic                          i_wb_cyc,
    input  logic                          i_wb_stb,
    input  logic                          i_wb_we,
    input  saturn_ctrl_pkg::instr_type_t  i_type,
    input  logic                          i_at_last,
    input  logic                          i_load_error,
    output logic                          o_wb_ack,
    output logic                          o_ready,
    output logic                          o_error,
    output logic                          o_exec,
    output logic                          o_clear_regs,
    output logic                          o_cnt_clear,
    output logic                          o_cnt_step,
    output saturn_ctrl_pkg::nibble_t      o_cnt_last,
    output logic                          o_push,
    output saturn_ctrl_pkg::entry_src_t   o_push_src,
    output saturn_ctrl_pkg::nibble_t      o_push_cmd
);

    localparam saturn_ctrl_pkg::nibble_t C_LAST    = saturn_ctrl_pkg::nibble_t'(C_NIBBLES - 1);
    localparam saturn_ctrl_pkg::nibble_t ADDR_LAST =
        saturn_ctrl_pkg::nibble_t'(ADDR_NIBBLES - 1);

    saturn_ctrl_pkg::ctrl_state_t state;
    saturn_ctrl_pkg::ctrl_state_t state_next;

    logic req;
    logic bad_type;
    logic is_config;
    logic is_reset;

    assign req       = (state == saturn_ctrl_pkg::ST_IDLE) && i_wb_cyc && i_wb_stb;
    assign bad_type  = (i_type > saturn_ctrl_pkg::INSTR_RESET);
    assign o_exec    = req && i_wb_we;                          // reads never execute
    assign is_config = o_exec && (i_type == saturn_ctrl_pkg::INSTR_CONFIG);
    assign is_reset  = o_exec && (i_type == saturn_ctrl_pkg::INSTR_RESET);
    assign o_wb_ack  = (state == saturn_ctrl_pkg::ST_ACK);

    always_comb begin
        state_next   = state;
        o_clear_regs = 1'b0;
        o_cnt_clear  = 1'b0;
        o_cnt_step   = 1'b0;
        o_cnt_last   = ADDR_LAST;
        o_push       = 1'b0;
        o_push_src   = saturn_ctrl_pkg::SRC_CMD;
        o_push_cmd   = saturn_ctrl_pkg::BUSCMD_PC_READ;
        case (state)
            saturn_ctrl_pkg::ST_CLEAR: begin
                o_clear_regs = 1'b1;
                o_cnt_step   = 1'b1;
                o_cnt_last   = C_LAST;
                if (i_at_last) begin
                    o_cnt_clear = 1'b1;                         // pc nibbles start at 0
                    state_next  = saturn_ctrl_pkg::ST_LOAD_PC;
                end
            end
            saturn_ctrl_pkg::ST_LOAD_PC: begin
                o_push     = 1'b1;
                o_push_cmd = saturn_ctrl_pkg::BUSCMD_LOAD_PC;
                state_next = saturn_ctrl_pkg::ST_PC_NIBBLES;
            end
            saturn_ctrl_pkg::ST_PC_NIBBLES: begin
                o_push     = 1'b1;
                o_push_src = saturn_ctrl_pkg::SRC_PC;
                o_cnt_step = 1'b1;
                if (i_at_last) begin
                    state_next = saturn_ctrl_pkg::ST_IDLE;
                end
            end
            saturn_ctrl_pkg::ST_IDLE: begin
                o_cnt_clear = 1'b1;                             // keep index parked at 0
                if (req) begin
                    if (is_config) begin
                        o_push     = 1'b1;
                        o_push_cmd = saturn_ctrl_pkg::BUSCMD_CONFIGURE;
                        state_next = saturn_ctrl_pkg::ST_CFG_NIBBLES;
                    end else if (is_reset) begin
                        o_push     = 1'b1;
                        o_push_cmd = saturn_ctrl_pkg::BUSCMD_RESET;
                        state_next = saturn_ctrl_pkg::ST_PC_READ;
                    end else begin
                        state_next = saturn_ctrl_pkg::ST_ACK;
                    end
                end
            end
            saturn_ctrl_pkg::ST_CFG_NIBBLES: begin
                o_push     = 1'b1;
                o_push_src = saturn_ctrl_pkg::SRC_C;            // C(A) goes out low first
                o_cnt_step = 1'b1;
                if (i_at_last) begin
                    state_next = saturn_ctrl_pkg::ST_PC_READ;
                end
            end
            saturn_ctrl_pkg::ST_PC_READ: begin
                o_push     = 1'b1;                              // restore devices
                state_next = saturn_ctrl_pkg::ST_ACK;
            end
            saturn_ctrl_pkg::ST_ACK: begin
                state_next = saturn_ctrl_pkg::ST_IDLE;
            end
            default: begin
                state_next = saturn_ctrl_pkg::ST_CLEAR;
            end
        endcase
    end

    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            state   <= saturn_ctrl_pkg::ST_CLEAR;
            o_ready <= 1'b0;
            o_error <= 1'b0;
        end else begin
            state <= state_next;
            if ((state == saturn_ctrl_pkg::ST_PC_NIBBLES) && i_at_last) begin
                o_ready <= 1'b1;                                // stays up until reset
            end
            if ((req && (!i_wb_we || bad_type)) || i_load_error) begin
                o_error <= 1'b1;                                // sticky
            end
        end
    end

endmodule

//--- design/saturn_nibble_counter.sv
`timescale 1ns/1ns

module saturn_nibble_counter (
    input  logic                      i_clk,
    input  logic                      i_reset,
    input  logic                      i_clear,
    input  logic                      i_step,
    input  saturn_ctrl_pkg::nibble_t  i_last,
    output saturn_ctrl_pkg::nibble_t  o_count,
    output logic                      o_at_last
);

    assign o_at_last = (o_count == i_last);

    always_ff @(posedge i_clk) begin
        if (i_reset || i_clear) begin
            o_count <= '0;
        end else if (i_step) begin
            o_count <= o_count + 4'd1;    // wraps at 16
        end
    end

endmodule

//--- design/saturn_nibble_regs.sv
`timescale 1ns/1ns

module saturn_nibble_regs #(
    parameter int C_NIBBLES    = 16,
    parameter int ADDR_NIBBLES = 5
) (
    input  logic                          i_clk,
    input  logic                          i_clear,
    input  saturn_ctrl_pkg::nibble_t      i_index,
    input  logic                          i_exec,
    input  saturn_ctrl_pkg::instr_word_t  i_word,
    input  saturn_ctrl_pkg::nibble_t      i_reg_p,
    input  saturn_ctrl_pkg::reg_sel_t     i_dbg_reg,
    input  saturn_ctrl_pkg::nibble_t      i_dbg_ptr,
    output saturn_ctrl_pkg::nibble_t      o_c_nibble,
    output saturn_ctrl_pkg::nibble_t      o_dbg_nibble,
    output logic                          o_load_error
);

    localparam int C_AW  = $clog2(C_NIBBLES);
    localparam int D0_AW = $clog2(ADDR_NIBBLES);

    saturn_ctrl_pkg::nibble_t c_regs  [C_NIBBLES];
    saturn_ctrl_pkg::nibble_t d0_regs [ADDR_NIBBLES];

    saturn_ctrl_pkg::instr_type_t word_type;
    saturn_ctrl_pkg::reg_sel_t    word_reg;
    saturn_ctrl_pkg::nibble_t     word_ptr;
    saturn_ctrl_pkg::nibble_t     word_imm;
    logic                         is_load;
    logic                         load_c;
    logic                         load_d0;

    assign word_type = i_word[15:12];
    assign word_reg  = i_word[11:8];
    assign word_ptr  = i_word[7:4];
    assign word_imm  = i_word[3:0];

    assign is_load      = i_exec && (word_type == saturn_ctrl_pkg::INSTR_LOAD);
    assign load_c       = is_load && (word_reg == saturn_ctrl_pkg::REG_C);
    assign load_d0      = is_load && (word_reg == saturn_ctrl_pkg::REG_D0);
    assign o_load_error = is_load && !load_c && !load_d0;

    assign o_c_nibble = c_regs[i_index[C_AW-1:0]];

    always_ff @(posedge i_clk) begin
        if (i_clear) begin
            c_regs[i_index[C_AW-1:0]] <= '0;
            if (i_index < ADDR_NIBBLES) begin
                d0_regs[i_index[D0_AW-1:0]] <= '0;    // D0 is shorter than the sweep
            end
        end else if (i_exec && (word_type == saturn_ctrl_pkg::INSTR_C_EQ_P)) begin
            c_regs[word_ptr[C_AW-1:0]] <= i_reg_p;
        end else if (load_c) begin
            c_regs[word_ptr[C_AW-1:0]] <= word_imm;
        end else if (load_d0 && (word_ptr < ADDR_NIBBLES)) begin
            d0_regs[word_ptr[D0_AW-1:0]] <= word_imm;
        end
    end

    always_comb begin
        o_dbg_nibble = '0;
        case (i_dbg_reg)
            saturn_ctrl_pkg::REG_C:  o_dbg_nibble = c_regs[i_dbg_ptr[C_AW-1:0]];
            saturn_ctrl_pkg::REG_D0: begin
                if (i_dbg_ptr < ADDR_NIBBLES) begin
                    o_dbg_nibble = d0_regs[i_dbg_ptr[D0_AW-1:0]];
                end
            end
            default: o_dbg_nibble = '0;
        endcase
    end

endmodule

//--- design/saturn_status_regs.sv
`timescale 1ns/1ns

module saturn_status_regs (
    input  logic                          i_clk,
    input  logic                          i_reset,
    input  logic                          i_exec,
    input  saturn_ctrl_pkg::instr_word_t  i_word,
    output saturn_ctrl_pkg::nibble_t      o_reg_p,
    output saturn_ctrl_pkg::nibble_t      o_reg_hst,
    output logic [15:0]                   o_reg_st,
    output logic                          o_reg_carry,
    output logic                          o_reg_mode
);

    saturn_ctrl_pkg::instr_type_t word_type;
    saturn_ctrl_pkg::nibble_t     word_ptr;
    saturn_ctrl_pkg::nibble_t     word_imm;

    assign word_type = i_word[15:12];
    assign word_ptr  = i_word[7:4];
    assign word_imm  = i_word[3:0];

    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            o_reg_p     <= '0;
            o_reg_hst   <= '0;
            o_reg_st    <= '0;
            o_reg_carry <= 1'b0;
            o_reg_mode  <= 1'b0;
        end else if (i_exec) begin
            case (word_type)
                saturn_ctrl_pkg::INSTR_P_EQ_N:    o_reg_p <= word_imm;
                saturn_ctrl_pkg::INSTR_CLRHST:    o_reg_hst <= o_reg_hst & ~word_imm;  // XM/SB/SR/MP
                saturn_ctrl_pkg::INSTR_ST_EQ:     o_reg_st[word_ptr] <= word_imm[0];
                saturn_ctrl_pkg::INSTR_SET_MODE:  o_reg_mode <= word_imm[0];    // 1 is decimal
                saturn_ctrl_pkg::INSTR_SET_CARRY: o_reg_carry <= word_imm[0];
                default: begin
                end
            endcase
        end
    end

endmodule

//--- design/saturn_bus_program.sv
`timescale 1ns/1ns

module saturn_bus_program (
    input  logic                          i_clk,
    input  logic                          i_reset,
    input  logic                          i_push,
    input  saturn_ctrl_pkg::entry_src_t   i_src,
    input  saturn_ctrl_pkg::nibble_t      i_cmd,
    input  saturn_ctrl_pkg::pc_t          i_pc,
    input  saturn_ctrl_pkg::nibble_t      i_index,
    input  saturn_ctrl_pkg::nibble_t      i_c_nibble,
    input  saturn_ctrl_pkg::prog_addr_t   i_prog_addr,
    output saturn_ctrl_pkg::bus_entry_t   o_prog_data,
    output saturn_ctrl_pkg::prog_addr_t   o_prog_count
);

    saturn_ctrl_pkg::bus_entry_t program_mem [32];
    saturn_ctrl_pkg::bus_entry_t entry;
    saturn_ctrl_pkg::pc_t        pc_shifted;

    assign pc_shifted  = i_pc >> {i_index, 2'b00};    // selected nibble lands in [3:0]
    assign o_prog_data = program_mem[i_prog_addr];

    always_comb begin
        case (i_src)
            saturn_ctrl_pkg::SRC_CMD: entry = {1'b1, i_cmd};
            saturn_ctrl_pkg::SRC_PC:  entry = {1'b0, pc_shifted[3:0]};
            default:                  entry = {1'b0, i_c_nibble};
        endcase
    end

    always_ff @(posedge i_clk) begin
        if (i_push) begin
            program_mem[o_prog_count] <= entry;
        end
    end

    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            o_prog_count <= '0;
        end else if (i_push) begin
            o_prog_count <= o_prog_count + 5'd1;    // ring of 32 entries
        end
    end

endmodule

//--- design/saturn_control_unit.sv
`timescale 1ns/1ns

module saturn_control_unit #(
    parameter int C_NIBBLES    = saturn_ctrl_pkg::C_NIBBLES,
    parameter int ADDR_NIBBLES = saturn_ctrl_pkg::ADDR_NIBBLES
) (
    input  logic                          i_clk,
    input  logic                          i_reset,
    input  logic                          i_wb_cyc,
    input  logic                          i_wb_stb,
    input  logic                          i_wb_we,
    input  saturn_ctrl_pkg::instr_word_t  i_wb_dat,
    input  saturn_ctrl_pkg::pc_t          i_pc,
    input  saturn_ctrl_pkg::prog_addr_t   i_prog_addr,
    input  saturn_ctrl_pkg::reg_sel_t     i_dbg_reg,
    input  saturn_ctrl_pkg::nibble_t      i_dbg_ptr,
    output logic                          o_wb_ack,
    output logic                          o_ready,
    output logic                          o_error,
    output saturn_ctrl_pkg::bus_entry_t   o_prog_data,
    output saturn_ctrl_pkg::prog_addr_t   o_prog_count,
    output saturn_ctrl_pkg::nibble_t      o_dbg_nibble,
    output saturn_ctrl_pkg::nibble_t      o_reg_p,
    output saturn_ctrl_pkg::nibble_t      o_reg_hst,
    output logic [15:0]                   o_reg_st,
    output logic                          o_reg_carry,
    output logic                          o_reg_mode
);

    logic                        exec;
    logic                        clear_regs;
    logic                        cnt_clear;
    logic                        cnt_step;
    saturn_ctrl_pkg::nibble_t    cnt_last;
    saturn_ctrl_pkg::nibble_t    count;
    logic                        at_last;
    logic                        push;
    saturn_ctrl_pkg::entry_src_t push_src;
    saturn_ctrl_pkg::nibble_t    push_cmd;
    saturn_ctrl_pkg::nibble_t    c_nibble;
    logic                        load_error;

    saturn_ctrl_fsm #(
        .C_NIBBLES    (C_NIBBLES),
        .ADDR_NIBBLES (ADDR_NIBBLES)
    ) u_fsm (
        .i_clk        (i_clk),
        .i_reset      (i_reset),
        .i_wb_cyc     (i_wb_cyc),
        .i_wb_stb     (i_wb_stb),
        .i_wb_we      (i_wb_we),
        .i_type       (i_wb_dat[15:12]),
        .i_at_last    (at_last),
        .i_load_error (load_error),
        .o_wb_ack     (o_wb_ack),
        .o_ready      (o_ready),
        .o_error      (o_error),
        .o_exec       (exec),
        .o_clear_regs (clear_regs),
        .o_cnt_clear  (cnt_clear),
        .o_cnt_step   (cnt_step),
        .o_cnt_last   (cnt_last),
        .o_push       (push),
        .o_push_src   (push_src),
        .o_push_cmd   (push_cmd)
    );

    saturn_nibble_counter u_counter (
        .i_clk     (i_clk),
        .i_reset   (i_reset),
        .i_clear   (cnt_clear),
        .i_step    (cnt_step),
        .i_last    (cnt_last),
        .o_count   (count),
        .o_at_last (at_last)
    );

    saturn_nibble_regs #(
        .C_NIBBLES    (C_NIBBLES),
        .ADDR_NIBBLES (ADDR_NIBBLES)
    ) u_nibble_regs (
        .i_clk        (i_clk),
        .i_clear      (clear_regs),
        .i_index      (count),
        .i_exec       (exec),
        .i_word       (i_wb_dat),
        .i_reg_p      (o_reg_p),      // C=P takes P as it was before this edge
        .i_dbg_reg    (i_dbg_reg),
        .i_dbg_ptr    (i_dbg_ptr),
        .o_c_nibble   (c_nibble),
        .o_dbg_nibble (o_dbg_nibble),
        .o_load_error (load_error)
    );

    saturn_status_regs u_status_regs (
        .i_clk       (i_clk),
        .i_reset     (i_reset),
        .i_exec      (exec),
        .i_word      (i_wb_dat),
        .o_reg_p     (o_reg_p),
        .o_reg_hst   (o_reg_hst),
        .o_reg_st    (o_reg_st),
        .o_reg_carry (o_reg_carry),
        .o_reg_mode  (o_reg_mode)
    );

    saturn_bus_program u_bus_program (
        .i_clk        (i_clk),
        .i_reset      (i_reset),
        .i_push       (push),
        .i_src        (push_src),
        .i_cmd        (push_cmd),
        .i_pc         (i_pc),
        .i_index      (count),
        .i_c_nibble   (c_nibble),
        .i_prog_addr  (i_prog_addr),
        .o_prog_data  (o_prog_data),
        .o_prog_count (o_prog_count)
    );

endmodule

//--- dv/saturn_ctrl_props.sv
`timescale 1ns/1ns

module saturn_ctrl_props (
    input logic       i_clk,
    input logic       i_reset,
    input logic       i_wb_cyc,
    input logic       i_wb_stb,
    input logic       i_wb_ack,
    input logic       i_ready,
    input logic [4:0] i_prog_count
);

    ack_needs_request: assert property (@(posedge i_clk) disable iff (i_reset)
        i_wb_ack |-> (i_wb_cyc && i_wb_stb))
        else $error("ack without cyc and stb");

    ack_single_cycle: assert property (@(posedge i_clk) disable iff (i_reset)
        i_wb_ack |=> !i_wb_ack)
        else $error("ack high for two cycles");

    ready_holds: assert property (@(posedge i_clk)
        (i_ready && !i_reset) |=> i_ready)
        else $error("ready fell without reset");

    count_step: assert property (@(posedge i_clk) disable iff (i_reset)
        (i_prog_count == $past(i_prog_count)) || (i_prog_count == $past(i_prog_count) + 5'd1))
        else $error("program count jumped");

endmodule

//--- dv/saturn_ctrl_checker.sv
`timescale 1ns/1ns

module saturn_ctrl_checker (
    input  logic        i_ready,
    input  logic        i_error,
    input  logic [4:0]  i_prog_data,
    input  logic [4:0]  i_prog_count,
    input  logic [3:0]  i_dbg_nibble,
    input  logic [3:0]  i_reg_p,
    input  logic [3:0]  i_reg_hst,
    input  logic [15:0] i_reg_st,
    input  logic        i_reg_carry,
    input  logic        i_reg_mode,
    output int          o_fail_count
);

    int test_fails = 0;
    int test_count = 0;
    int tests_failed = 0;

    initial o_fail_count = 0;

    task automatic compare(input string name, input logic [31:0] exp, input logic [31:0] act);
        if (exp !== act) begin
            $display("[FAIL] t=%0t %s expected %0h actual %0h", $time, name, exp, act);
            o_fail_count++;
            test_fails++;
        end
    endtask

    task automatic note_failure(input string msg);
        $display("%0t: %s", $time, msg);
        o_fail_count++;
        test_fails++;
    endtask

    // compares every status output and the error flag
    task automatic check_status(input logic [3:0] p, input logic [3:0] hst,
                                input logic [15:0] st, input logic carry,
                                input logic mode, input logic err);
        compare("o_reg_p", p, i_reg_p);
        compare("o_reg_hst", hst, i_reg_hst);
        compare("o_reg_st", st, i_reg_st);
        compare("o_reg_carry", carry, i_reg_carry);
        compare("o_reg_mode", mode, i_reg_mode);
        compare("o_error", err, i_error);
    endtask

    task automatic check_dbg(input logic [3:0] exp);
        compare("o_dbg_nibble", exp, i_dbg_nibble);
    endtask

    task automatic check_prog(input logic [4:0] exp);
        compare("o_prog_data", exp, i_prog_data);
    endtask

    task automatic check_count(input logic [4:0] exp);
        compare("o_prog_count", exp, i_prog_count);
    endtask

    task automatic check_ready(input logic exp);
        compare("o_ready", exp, i_ready);
    endtask

    task automatic test_done(input string name);
        test_count++;
        if (test_fails == 0) begin
            $display("test %-12s ok", name);
        end else begin
            $display("test %-12s %0d mismatches", name, test_fails);
            tests_failed++;
        end
        test_fails = 0;
    endtask

    task automatic summary();
        $display("tests run %0d, tests failed %0d, checks failed %0d",
                 test_count, tests_failed, o_fail_count);
    endtask

endmodule

//--- dv/tb_saturn_ctrl.sv
`timescale 1ns/1ns

module tb_saturn_ctrl;

    localparam int N_STATUS = 40;
    localparam int N_LOAD   = 40;
    localparam int N_BUS    = 12;
    localparam int N_MIX    = 60;
    localparam int STARTUP  = 30;                       // reset plus 22 cycles, rounded up
    localparam int LIMIT_NS = ((N_STATUS + N_LOAD + N_BUS + N_MIX) * (9 + 3) + 2 * STARTUP) * 20;

    logic        i_clk, i_reset, i_wb_cyc, i_wb_stb, i_wb_we;
    logic [15:0] i_wb_dat;
    logic [19:0] i_pc;
    logic [4:0]  i_prog_addr;
    logic [3:0]  i_dbg_reg, i_dbg_ptr;
    logic        o_wb_ack, o_ready, o_error, o_reg_carry, o_reg_mode;
    logic [4:0]  o_prog_data, o_prog_count;
    logic [3:0]  o_dbg_nibble, o_reg_p, o_reg_hst;
    logic [15:0] o_reg_st;
    int          fail_count;
    int          seed;

    // reference model state
    logic [3:0]  m_c [16];
    logic [3:0]  m_d0 [5];
    logic [3:0]  m_p, m_hst;
    logic [15:0] m_st;
    logic        m_carry, m_mode, m_err;
    logic [4:0]  m_prog [32];
    logic [4:0]  m_ptr;

    saturn_control_unit dut0 (.*);

    saturn_ctrl_checker chk0 (
        .i_ready(o_ready), .i_error(o_error), .i_prog_data(o_prog_data),
        .i_prog_count(o_prog_count), .i_dbg_nibble(o_dbg_nibble), .i_reg_p(o_reg_p),
        .i_reg_hst(o_reg_hst), .i_reg_st(o_reg_st), .i_reg_carry(o_reg_carry),
        .i_reg_mode(o_reg_mode), .o_fail_count(fail_count)
    );

    bind saturn_control_unit saturn_ctrl_props props0 (
        .i_clk(i_clk), .i_reset(i_reset), .i_wb_cyc(i_wb_cyc), .i_wb_stb(i_wb_stb),
        .i_wb_ack(o_wb_ack), .i_ready(o_ready), .i_prog_count(o_prog_count)
    );

    initial begin
        i_clk = 1'b0;
        forever #10 i_clk = ~i_clk;
    end

    initial begin
        #(LIMIT_NS);
        $display("watchdog expired before the tests completed");
        $display("TESTBENCH FAILED");
        $finish;
    end

    task automatic push_entry(input logic [4:0] e);
        m_prog[m_ptr] = e;
        m_ptr = m_ptr + 5'd1;
    endtask

    // state after reset and the startup program
    task automatic model_reset();
        for (int i = 0; i < 16; i++) m_c[i] = 4'h0;
        for (int i = 0; i < 5; i++) m_d0[i] = 4'h0;
        {m_p, m_hst, m_st, m_carry, m_mode, m_err} = '0;
        m_ptr = 5'd0;
        push_entry({1'b1, saturn_ctrl_pkg::BUSCMD_LOAD_PC});
        for (int i = 0; i < 5; i++) push_entry({1'b0, i_pc[4*i +: 4]});
    endtask

    task automatic model_exec(input logic [15:0] w, input logic we);
        logic [3:0] typ, rsel, ptr, imm;
        {typ, rsel, ptr, imm} = w;
        if (!we || typ > 4'd9) begin
            m_err = 1'b1;
        end else begin
            case (typ)
                4'd1: m_p = imm;
                4'd2: m_c[ptr] = m_p;
                4'd3: m_hst = m_hst & ~imm;
                4'd4: m_st[ptr] = imm[0];
                4'd5: m_mode = imm[0];
                4'd6: m_carry = imm[0];
                4'd7: begin
                    if (rsel == 4'd2) m_c[ptr] = imm;
                    else if (rsel == 4'd4) begin
                        if (ptr < 5) m_d0[ptr] = imm;     // out-of-range pointer is ignored
                    end else m_err = 1'b1;
                end
                4'd8: begin
                    push_entry({1'b1, saturn_ctrl_pkg::BUSCMD_CONFIGURE});
                    for (int i = 0; i < 5; i++) push_entry({1'b0, m_c[i]});
                    push_entry({1'b1, saturn_ctrl_pkg::BUSCMD_PC_READ});
                end
                4'd9: begin
                    push_entry({1'b1, saturn_ctrl_pkg::BUSCMD_RESET});
                    push_entry({1'b1, saturn_ctrl_pkg::BUSCMD_PC_READ});
                end
                default: ;
            endcase
        end
    endtask

    // kind 0 status, 1 load/C=P, 2 bus, 3 anything
    function automatic logic [15:0] rand_word(input int kind);
        logic [31:0] r;
        logic [3:0]  typ, rsel;
        r = $random(seed);
        case (kind)
            0: typ = (r[18:16] % 5 == 0) ? 4'd1 : 4'd2 + 4'(r[18:16] % 5);
            1: typ = r[16] ? 4'd2 : 4'd7;
            2: typ = r[16] ? 4'd8 : 4'd9;
            default: typ = (r[20:16] < 5'd24) ? 4'(r[20:16] % 10) : 4'd10 + 4'(r[20:16] % 6);
        endcase
        rsel = r[17] ? 4'd2 : 4'd4;
        if (kind == 3 && r[23:22] == 2'b00) rsel = r[27:24];
        return {typ, rsel, r[7:4], r[3:0]};
    endfunction

    task automatic write_word(input logic [15:0] w, input logic we);
        int n;
        int exp_lat;
        exp_lat = 1;                                    // simple, read and unsupported cycles
        if (we && w[15:12] == 4'd8) exp_lat = 7;        // CONFIGURE, five C nibbles, PC_READ
        if (we && w[15:12] == 4'd9) exp_lat = 2;        // RESET, PC_READ
        @(posedge i_clk);
        #2;
        {i_wb_cyc, i_wb_stb, i_wb_we, i_wb_dat} = {1'b1, 1'b1, we, w};
        n = 0;
        do begin
            @(posedge i_clk);
            #1;
            n++;
        end while (!o_wb_ack && n < 20);
        if (!o_wb_ack) begin
            chk0.note_failure("no ack for a Wishbone cycle within 20 cycles");
        end else begin
            chk0.compare("o_wb_ack latency", 32'(exp_lat), 32'(n));
        end
        @(posedge i_clk);
        #2;
        {i_wb_cyc, i_wb_stb, i_wb_we} = 3'b000;
        model_exec(w, we);
    endtask

    task automatic sweep_regs();
        for (int i = 0; i < 16; i++) begin
            i_dbg_ptr = 4'(i);
            i_dbg_reg = 4'd2;
            #1 chk0.check_dbg(m_c[i]);
            i_dbg_reg = 4'd4;
            #1 chk0.check_dbg(i < 5 ? m_d0[i] : 4'h0);
            i_dbg_reg = 4'd3;
            #1 chk0.check_dbg(4'h0);
        end
    endtask

    task automatic check_program();
        for (int a = 0; a < 32; a++) begin
            i_prog_addr = 5'(a);
            #1 chk0.check_prog(m_prog[a]);
        end
        chk0.check_count(m_ptr);
    endtask

    task automatic reset_and_startup();
        int n;
        i_pc = $random(seed);
        @(posedge i_clk);
        #2 i_reset = 1'b1;
        repeat (2) @(posedge i_clk);
        #2 i_reset = 1'b0;
        chk0.check_ready(1'b0);                         // reset drops ready
        chk0.check_count(5'd0);
        model_reset();
        n = 0;
        do begin
            @(posedge i_clk);
            #1;
            n++;
        end while (!o_ready && n < 40);
        chk0.compare("o_ready latency", 32'd22, 32'(n));
        check_program();
        sweep_regs();
        chk0.check_status(m_p, m_hst, m_st, m_carry, m_mode, m_err);
        chk0.test_done("startup");
    endtask

    initial begin
        logic [15:0] w;
        seed = 32'h1d8e;
        {i_reset, i_wb_cyc, i_wb_stb, i_wb_we, i_wb_dat, i_pc} = {1'b1, 39'd0};
        {i_prog_addr, i_dbg_reg, i_dbg_ptr} = '0;
        for (int a = 0; a < 32; a++) m_prog[a] = 5'bx;    // never written until pushed
        reset_and_startup();
        for (int i = 0; i < N_STATUS; i++) begin
            write_word(rand_word(0), 1'b1);
            chk0.check_status(m_p, m_hst, m_st, m_carry, m_mode, m_err);
        end
        chk0.test_done("status");
        for (int i = 0; i < N_LOAD; i++) write_word(rand_word(1), 1'b1);
        sweep_regs();
        chk0.check_status(m_p, m_hst, m_st, m_carry, m_mode, m_err);
        chk0.test_done("load");
        for (int i = 0; i < N_BUS; i++) begin
            write_word(rand_word(2), 1'b1);
            check_program();
        end
        chk0.test_done("bus");
        for (int i = 0; i < N_MIX; i++) begin
            w = rand_word(3);
            write_word(w, ($random(seed) & 7) != 0);       // about one read in eight
            chk0.check_status(m_p, m_hst, m_st, m_carry, m_mode, m_err);
            chk0.check_count(m_ptr);
        end
        sweep_regs();
        chk0.test_done("errors");
        reset_and_startup();
        chk0.summary();
        if (fail_count == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule

//--- saturn_ctrl.f
design/saturn_ctrl_pkg.sv
design/saturn_ctrl_fsm.sv
design/saturn_nibble_counter.sv
design/saturn_nibble_regs.sv
design/saturn_status_regs.sv
design/saturn_bus_program.sv
design/saturn_control_unit.sv
dv/saturn_ctrl_props.sv
dv/saturn_ctrl_checker.sv
dv/tb_saturn_ctrl.sv

//--- run.sh
#!/bin/sh
# compile and run the saturn control unit testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_saturn_ctrl -f saturn_ctrl.f -o sim_tb
if [ $? -ne 0 ]; then
    echo "compile failed"
    exit 1
fi

out=$(./obj_dir/sim_tb)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if echo "$out" | grep -q "TESTBENCH PASSED"; then
    exit 0
fi
exit 1
